/* hdl/boot_ram.sv */
`default_nettype none

module boot_ram #(
   parameter int MEM_WORDS = 2048
) (
   input  wire                 clk,
   input  wire                 rst_n_i,

   input  sp_bus_pkg::word_t   i_adr_i,
   input  wire                 i_stb_i,
   output sp_bus_pkg::word_t   i_dat_o,
   output logic                i_ack_o,

   sp_wb_if.slave              d
);

   localparam int IDX_W  = $clog2(MEM_WORDS);
   localparam int LANE_W = sp_mem_pkg::LANE_W;

   logic [IDX_W-1:0]  i_idx;
   logic [IDX_W-1:0]  d_idx;
   logic [IDX_W-1:0]  rd_idx;
   logic              i_access;
   logic              d_active;
   logic              d_wr;
   logic              d_rd_go;
   logic              rd_en;
   logic              d_ack_q;
   sp_bus_pkg::word_t rd_data;

   assign i_idx = i_adr_i[sp_mem_pkg::WORD_IDX_LSB +: IDX_W];
   assign d_idx = d.adr[sp_mem_pkg::WORD_IDX_LSB +: IDX_W];

   assign i_access = i_stb_i && !i_ack_o;
   assign d_active = d.cyc && d.stb && !d_ack_q;
   assign d_wr     = d_active && d.we;

   // A data read waits while the instruction port owns the read path.
   assign d_rd_go = d_active && !d.we && !i_access;

   assign rd_en  = i_access || d_rd_go;
   assign rd_idx = i_access ? i_idx : d_idx;

   for (genvar l = 0; l < sp_bus_pkg::LANES; l++) begin : g_lane
      logic [LANE_W-1:0] lane_mem [MEM_WORDS];
      logic [LANE_W-1:0] rd_byte;

      always_ff @(posedge clk) begin
         if (d_wr && d.sel[l]) begin
            lane_mem[d_idx] <= d.dat_m[l*LANE_W +: LANE_W];
         end
         if (rd_en) begin
            rd_byte <= lane_mem[rd_idx];
         end
      end

      assign rd_data[l*LANE_W +: LANE_W] = rd_byte;
   end

   // Single-cycle acks, cleared right after they are seen.
   always_ff @(posedge clk) begin
      if (!rst_n_i || i_ack_o) begin
         i_ack_o <= 1'b0;
      end else if (i_stb_i) begin
         i_ack_o <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i || d_ack_q) begin
         d_ack_q <= 1'b0;
      end else if (d_wr || d_rd_go) begin
         d_ack_q <= 1'b1;
      end
   end

   // Both ports share one read register; their acks never coincide with two reads.
   assign i_dat_o = rd_data;
   assign d.dat_s = rd_data;
   assign d.ack   = d_ack_q;
   assign d.err   = 1'b0;

endmodule

`default_nettype wire

/* hdl/byte_lane_bridge.sv */
`default_nettype none

module byte_lane_bridge (
   input  wire                                 clk,
   input  wire                                 rst_n_i,

   sp_wb_if.slave                              s,

   output logic [sp_bus_pkg::EXT_ADR_W-1:0]    ext_adr_o,
   output sp_bus_pkg::byte_t                   ext_dat_o,
   input  sp_bus_pkg::byte_t                   ext_dat_i,
   output logic                                ext_we_o,
   output logic                                ext_sel_o,
   output logic                                ext_stb_o,
   output logic                                ext_cyc_o,
   input  wire                                 ext_ack_i
);

   localparam int DAT_W     = sp_bus_pkg::DAT_W;
   localparam int EXT_DAT_W = sp_bus_pkg::EXT_DAT_W;

   logic [1:0]        sub_q;
   logic [1:0]        lane_idx;
   logic              ack_q;
   logic              byte_done;
   sp_bus_pkg::word_t shift_q;

   // Sub-address 0 carries the most significant lane.
   assign lane_idx = ~sub_q;

   assign ext_cyc_o = s.cyc;
   assign ext_stb_o = s.cyc && s.stb && !ack_q;
   assign ext_we_o  = s.cyc && s.we;
   assign ext_adr_o = {s.adr[sp_bus_pkg::EXT_ADR_W-1:sp_mem_pkg::WORD_IDX_LSB], sub_q};
   assign ext_dat_o = s.dat_m[lane_idx*EXT_DAT_W +: EXT_DAT_W];
   assign ext_sel_o = s.sel[lane_idx];

   assign byte_done = ext_stb_o && ext_ack_i;

   always_ff @(posedge clk) begin
      if (!rst_n_i || !s.cyc) begin
         sub_q <= 2'd0;
      end else if (byte_done) begin
         sub_q <= sub_q + 2'd1;
      end
   end

   // Word ack follows the fourth byte ack by one cycle.
   always_ff @(posedge clk) begin
      if (!rst_n_i || ack_q) begin
         ack_q <= 1'b0;
      end else if (byte_done && sub_q == 2'd3) begin
         ack_q <= 1'b1;
      end
   end

   // Read bytes enter at the bottom, so the first one ends up on top.
   always_ff @(posedge clk) begin
      if (byte_done) begin
         shift_q <= {shift_q[DAT_W-EXT_DAT_W-1:0], ext_dat_i};
      end
   end

   assign s.dat_s = shift_q;
   assign s.ack   = ack_q;
   assign s.err   = 1'b0;

endmodule

`default_nettype wire

/* hdl/data_port_router.sv */
`default_nettype none

module data_port_router (
   input  wire        clk,
   input  wire        rst_n_i,

   sp_wb_if.slave     core,
   sp_wb_if.master    mem,
   sp_wb_if.master    ext
);

   localparam int ADR_W     = sp_bus_pkg::ADR_W;
   localparam int MEM_TAG_W = sp_bus_pkg::MEM_TAG_W;
   localparam int EXT_TAG_W = sp_bus_pkg::EXT_TAG_W;

   sp_bus_pkg::region_e region;
   logic                err_q;

   always_comb begin
      if (core.adr[ADR_W-1 -: MEM_TAG_W] == sp_bus_pkg::MEM_TAG) begin
         region = sp_bus_pkg::REGION_MEM;
      end else if (core.adr[ADR_W-1 -: EXT_TAG_W] == sp_bus_pkg::EXT_WINDOW) begin
         region = sp_bus_pkg::REGION_EXT;
      end else begin
         region = sp_bus_pkg::REGION_NONE;
      end
   end

   // Payload goes to both targets, only the selected one sees a strobe.
   assign mem.adr   = core.adr;
   assign mem.dat_m = core.dat_m;
   assign mem.we    = core.we;
   assign mem.sel   = core.sel;
   assign mem.cyc   = core.cyc && (region == sp_bus_pkg::REGION_MEM);
   assign mem.stb   = core.stb && (region == sp_bus_pkg::REGION_MEM);

   assign ext.adr   = core.adr;
   assign ext.dat_m = core.dat_m;
   assign ext.we    = core.we;
   assign ext.sel   = core.sel;
   assign ext.cyc   = core.cyc && (region == sp_bus_pkg::REGION_EXT);
   assign ext.stb   = core.stb && (region == sp_bus_pkg::REGION_EXT);

   // Unmapped accesses get a one-cycle error instead of hanging.
   always_ff @(posedge clk) begin
      if (!rst_n_i || err_q) begin
         err_q <= 1'b0;
      end else if (core.cyc && core.stb && region == sp_bus_pkg::REGION_NONE) begin
         err_q <= 1'b1;
      end
   end

   always_comb begin
      case (region)
         sp_bus_pkg::REGION_MEM: begin
            core.dat_s = mem.dat_s;
            core.ack   = mem.ack;
            core.err   = mem.err;
         end
         sp_bus_pkg::REGION_EXT: begin
            core.dat_s = ext.dat_s;
            core.ack   = ext.ack;
            core.err   = ext.err;
         end
         default: begin
            core.dat_s = '0;
            core.ack   = 1'b0;
            core.err   = err_q;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hdl/sp_bus.sv */
`default_nettype none

module sp_bus #(
   parameter int MEM_WORDS = sp_mem_pkg::MEM_WORDS_DEFAULT
) (
   input  wire                                 clk,
   input  wire                                 rst_n_i,

   // Instruction port, read only.
   input  wire  [sp_bus_pkg::ADR_W-1:0]        iwb_adr_i,
   input  wire                                 iwb_stb_i,
   input  wire                                 iwb_cyc_i,
   output sp_bus_pkg::word_t                   iwb_dat_o,
   output logic                                iwb_ack_o,

   // Data port.
   input  wire  [sp_bus_pkg::ADR_W-1:0]        dwb_adr_i,
   input  sp_bus_pkg::word_t                   dwb_dat_i,
   input  wire                                 dwb_we_i,
   input  wire  [sp_bus_pkg::LANES-1:0]        dwb_sel_i,
   input  wire                                 dwb_stb_i,
   input  wire                                 dwb_cyc_i,
   output sp_bus_pkg::word_t                   dwb_dat_o,
   output logic                                dwb_ack_o,
   output logic                                dwb_err_o,

   // External 8-bit bus.
   output logic [sp_bus_pkg::EXT_ADR_W-1:0]    ext_adr_o,
   output sp_bus_pkg::byte_t                   ext_dat_o,
   input  sp_bus_pkg::byte_t                   ext_dat_i,
   output logic                                ext_we_o,
   output logic                                ext_sel_o,
   output logic                                ext_stb_o,
   output logic                                ext_cyc_o,
   input  wire                                 ext_ack_i
);

   sp_wb_if #(.dat_t(sp_bus_pkg::word_t)) core_wb ();
   sp_wb_if #(.dat_t(sp_bus_pkg::word_t)) mem_wb ();
   sp_wb_if #(.dat_t(sp_bus_pkg::word_t)) ext_wb ();

   assign core_wb.adr   = dwb_adr_i;
   assign core_wb.dat_m = dwb_dat_i;
   assign core_wb.we    = dwb_we_i;
   assign core_wb.sel   = dwb_sel_i;
   assign core_wb.stb   = dwb_stb_i;
   assign core_wb.cyc   = dwb_cyc_i;
   assign dwb_dat_o     = core_wb.dat_s;
   assign dwb_ack_o     = core_wb.ack;
   assign dwb_err_o     = core_wb.err;

   data_port_router u_router (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .core    (core_wb.slave),
      .mem     (mem_wb.master),
      .ext     (ext_wb.master)
   );

   boot_ram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_boot_ram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .i_adr_i (iwb_adr_i),
      .i_stb_i (iwb_stb_i && iwb_cyc_i),
      .i_dat_o (iwb_dat_o),
      .i_ack_o (iwb_ack_o),
      .d       (mem_wb.slave)
   );

   byte_lane_bridge u_bridge (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .s         (ext_wb.slave),
      .ext_adr_o (ext_adr_o),
      .ext_dat_o (ext_dat_o),
      .ext_dat_i (ext_dat_i),
      .ext_we_o  (ext_we_o),
      .ext_sel_o (ext_sel_o),
      .ext_stb_o (ext_stb_o),
      .ext_cyc_o (ext_cyc_o),
      .ext_ack_i (ext_ack_i)
   );

endmodule

`default_nettype wire

/* hdl/sp_bus_pkg.sv */
`default_nettype none

package sp_bus_pkg;

   // Core side and external bus widths.
   localparam int ADR_W     = 32;
   localparam int DAT_W     = 32;
   localparam int EXT_DAT_W = 8;
   localparam int EXT_ADR_W = 24;
   localparam int LANES     = DAT_W / EXT_DAT_W;

   typedef logic [DAT_W-1:0]     word_t;
   typedef logic [EXT_DAT_W-1:0] byte_t;

   // Boot memory sits where the top address bits are zero.
   localparam int             MEM_TAG_W = 2;
   localparam logic [MEM_TAG_W-1:0] MEM_TAG = '0;

   // External window is selected by the top address byte.
   localparam int             EXT_TAG_W  = 8;
   localparam logic [EXT_TAG_W-1:0] EXT_WINDOW = 8'h80;

   typedef enum logic [1:0] {
      REGION_MEM  = 2'd0,
      REGION_EXT  = 2'd1,
      REGION_NONE = 2'd2
   } region_e;

endpackage

`default_nettype wire

/* hdl/sp_mem_pkg.sv */
`default_nettype none

package sp_mem_pkg;

   // Boot memory depth in 32-bit words.
   localparam int MEM_WORDS_DEFAULT = 2048;

   // Width of one memory lane.
   localparam int LANE_W = 8;

   // Byte offset bits below the word index.
   localparam int WORD_IDX_LSB = 2;

endpackage

`default_nettype wire

/* hdl/sp_wb_if.sv */
`default_nettype none

interface sp_wb_if #(
   parameter type dat_t = logic [31:0]
);

   logic [sp_bus_pkg::ADR_W-1:0] adr;
   dat_t                         dat_m;
   logic                         we;
   logic [sp_bus_pkg::LANES-1:0] sel;
   logic                         stb;
   logic                         cyc;
   dat_t                         dat_s;
   logic                         ack;
   logic                         err;

   modport master (
      output adr, dat_m, we, sel, stb, cyc,
      input  dat_s, ack, err
   );

   modport slave (
      input  adr, dat_m, we, sel, stb, cyc,
      output dat_s, ack, err
   );

endinterface

`default_nettype wire

/* sp_bus.f */
hdl/sp_bus_pkg.sv
hdl/sp_mem_pkg.sv
hdl/sp_wb_if.sv
hdl/boot_ram.sv
hdl/byte_lane_bridge.sv
hdl/data_port_router.sv
hdl/sp_bus.sv
tests/sp_bus_assert.sv
tests/sp_bus_checker.sv
tests/sp_bus_tb.sv

/* tests/sp_bus_assert.sv */
`default_nettype none

module sp_bus_assert (
   input wire clk,
   input wire rst_n_i,
   input wire iwb_stb_i,
   input wire iwb_ack_o,
   input wire dwb_stb_i,
   input wire dwb_cyc_i,
   input wire dwb_ack_o,
   input wire dwb_err_o,
   input wire ext_stb_o,
   input wire ext_ack_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_count = 0;

   // One access gets a single response, never an ack and an err.
   ack_err_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
      (dwb_ack_o || dwb_err_o) |=> !(dwb_ack_o || dwb_err_o))
      else begin
         fail_count++;
         $error("dwb ack and err given for the same access");
      end

   dwb_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
      dwb_ack_o |-> $past(dwb_stb_i && dwb_cyc_i))
      else begin
         fail_count++;
         $error("dwb ack without strobe");
      end

   iwb_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
      iwb_ack_o |-> $past(iwb_stb_i))
      else begin
         fail_count++;
         $error("iwb ack without strobe");
      end

   ext_stb_held: assert property (@(posedge clk) disable iff (!rst_n_i)
      ext_stb_o && !ext_ack_i |=> ext_stb_o)
      else begin
         fail_count++;
         $error("ext strobe dropped before ack");
      end

endmodule

bind sp_bus sp_bus_assert u_sva (
   .clk       (clk),
   .rst_n_i   (rst_n_i),
   .iwb_stb_i (iwb_stb_i),
   .iwb_ack_o (iwb_ack_o),
   .dwb_stb_i (dwb_stb_i),
   .dwb_cyc_i (dwb_cyc_i),
   .dwb_ack_o (dwb_ack_o),
   .dwb_err_o (dwb_err_o),
   .ext_stb_o (ext_stb_o),
   .ext_ack_i (ext_ack_i)
);

`default_nettype wire

/* tests/sp_bus_checker.sv */
`default_nettype none

module sp_bus_checker (
   input wire clk_i
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_OPS = 20;

   logic [107:0] golden [N_OPS];
   int           idx = 0;
   int           error_count = 0;
   int           check_count = 0;
   int           ext_cnt = 0;
   bit           i_done = 0;
   bit           d_done = 0;

   initial $readmemh("tests/sp_bus_golden.hex", golden);

   // Region code 0 boot memory, 1 external window, 2 unmapped.
   function automatic logic [1:0] region_of(input logic [31:0] adr);
      if (adr[31:30] == 2'b00) return 2'd0;
      if (adr[31:24] == 8'h80) return 2'd1;
      return 2'd2;
   endfunction

   function automatic string test_name(input logic [107:0] op);
      if (op[107:104] == 4'd1) return "ifetch";
      if (op[107:104] == 4'd2) return "contention";
      case (region_of(op[99:68]))
         2'd0: return "mem_rw";
         2'd1: return op[100] ? "ext_write" : "ext_read";
         default: return "unmapped";
      endcase
   endfunction

   task automatic check_val(input string name, input string sig,
                            input logic [31:0] exp, input logic [31:0] act);
      check_count++;
      if (exp !== act) begin
         error_count++;
         $display("mismatch %s %s: expected %h, actual %h", name, sig, exp, act);
      end
   endtask

   task automatic fail(input string msg);
      error_count++;
      $display("error: %s", msg);
   endtask

   always @(posedge clk_i) begin : watch
      logic [107:0] op;
      logic [3:0]   port;
      logic [31:0]  d_adr;
      logic [1:0]   rgn;
      string        name;
      if (sp_bus_tb.u_dut.rst_n_i && idx < N_OPS) begin
         op    = golden[idx];
         port  = op[107:104];
         d_adr = (port == 4'd2) ? op[99:68] + 32'd4 : op[99:68];
         rgn   = region_of(d_adr);
         name  = test_name(op);
         if (sp_bus_tb.u_dut.iwb_ack_o) begin
            if (port == 4'd0) begin
               fail("instruction ack while no fetch was issued");
            end else begin
               check_val(name, "iwb_dat_o", (port == 4'd2) ? op[63:32] : op[31:0],
                         sp_bus_tb.u_dut.iwb_dat_o);
               i_done = 1;
            end
         end
         if (sp_bus_tb.u_dut.ext_cyc_o || sp_bus_tb.u_dut.ext_stb_o) begin
            if (rgn != 2'd1 || port == 4'd1) begin
               fail("external bus active outside the external window");
            end else if (sp_bus_tb.u_dut.ext_stb_o && sp_bus_tb.u_dut.ext_ack_i) begin
               // Sub-address counts up, lane order is most significant first.
               check_val(name, "ext_cyc_o", 32'd1, sp_bus_tb.u_dut.ext_cyc_o);
               check_val(name, "ext_adr_o", {8'h0, d_adr[23:2], 2'(ext_cnt)},
                         {8'h0, sp_bus_tb.u_dut.ext_adr_o});
               check_val(name, "ext_we_o", op[100], sp_bus_tb.u_dut.ext_we_o);
               if (op[100]) begin
                  check_val(name, "ext_dat_o", op[63-8*ext_cnt -: 8],
                            sp_bus_tb.u_dut.ext_dat_o);
                  check_val(name, "ext_sel_o", op[67-ext_cnt], sp_bus_tb.u_dut.ext_sel_o);
               end
               ext_cnt++;
            end
         end
         if (sp_bus_tb.u_dut.dwb_ack_o || sp_bus_tb.u_dut.dwb_err_o) begin
            if (port == 4'd1) begin
               fail("data port answered while only a fetch was issued");
            end else begin
               check_val(name, "dwb_err_o", rgn == 2'd2, sp_bus_tb.u_dut.dwb_err_o);
               check_val(name, "dwb_ack_o", rgn != 2'd2, sp_bus_tb.u_dut.dwb_ack_o);
               if (rgn != 2'd2 && !op[100]) begin
                  check_val(name, "dwb_dat_o", op[31:0], sp_bus_tb.u_dut.dwb_dat_o);
               end
               if (rgn == 2'd1) begin
                  check_val(name, "ext byte count", 32'd4, ext_cnt);
               end
               if (port == 4'd2 && !i_done) begin
                  fail("data ack came before the instruction ack");
               end
               d_done = 1;
            end
         end
         if ((i_done || port == 4'd0) && (d_done || port == 4'd1)) begin
            idx++;
            i_done  = 0;
            d_done  = 0;
            ext_cnt = 0;
         end
      end
   end

   function automatic int total_errors();
      return error_count + sp_bus_tb.u_dut.u_sva.fail_count;
   endfunction

   task automatic print_summary();
      if (idx != N_OPS) begin
         fail($sformatf("only %0d of %0d operations completed", idx, N_OPS));
      end
      $display("checker: %0d checks, %0d errors, %0d assertion failures",
               check_count, error_count, sp_bus_tb.u_dut.u_sva.fail_count);
   endtask

endmodule

`default_nettype wire

/* tests/sp_bus_golden.hex */
// port(0 data,1 ifetch,2 both) we addr sel wdata exp; port 2 fetches addr and reads addr+4
// For port 2 the wdata column holds the expected instruction word.
0_1_00000000_f_11223344_00000000
0_1_00000004_f_a5a5a5a5_00000000
0_1_00000004_5_00c300c3_00000000
0_1_00000008_f_deadbeef_00000000
0_1_00000008_8_01000000_00000000
0_1_00001ffc_f_0badf00d_00000000
0_0_00000000_f_00000000_11223344
0_0_00000004_f_00000000_a5c3a5c3
0_0_00000008_f_00000000_01adbeef
0_0_00001ffc_f_00000000_0badf00d
1_0_00000000_0_00000000_11223344
1_0_00000008_0_00000000_01adbeef
1_0_00001ffc_0_00000000_0badf00d
2_0_00000000_f_11223344_a5c3a5c3
2_0_00000004_f_a5c3a5c3_01adbeef
0_0_80001230_f_00000000_6a6b6869
0_0_800000f4_f_00000000_aeafacad
0_1_80000100_f_cafef00d_00000000
0_1_80000104_9_12345678_00000000
0_0_40000000_f_00000000_00000000

/* tests/sp_bus_tb.sv */
`default_nettype none

module sp_bus_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_OPS = 20;
   // Worst external access with slave delays fits well inside 40 cycles.
   localparam int LIMIT = N_OPS * 40;

   logic        clk;
   logic        rst_n;
   logic [31:0] iwb_adr;
   logic        iwb_stb;
   logic        iwb_cyc;
   logic [31:0] iwb_dat;
   logic        iwb_ack;
   logic [31:0] dwb_adr;
   logic [31:0] dwb_wdat;
   logic        dwb_we;
   logic [3:0]  dwb_sel;
   logic        dwb_stb;
   logic        dwb_cyc;
   logic [31:0] dwb_rdat;
   logic        dwb_ack;
   logic        dwb_err;
   logic [23:0] ext_adr;
   logic [7:0]  ext_wdat;
   logic [7:0]  ext_rdat;
   logic        ext_we;
   logic        ext_sel;
   logic        ext_stb;
   logic        ext_cyc;
   logic        ext_ack;

   logic [107:0] golden [N_OPS];
   int           cycles = 0;
   bit           slave_busy = 0;
   int           slave_delay = 0;
   logic         ext_stb_q = 1'b0;
   logic [23:0]  ext_adr_q = '0;

   sp_bus #(.MEM_WORDS(2048)) u_dut (
      .clk(clk), .rst_n_i(rst_n),
      .iwb_adr_i(iwb_adr), .iwb_stb_i(iwb_stb), .iwb_cyc_i(iwb_cyc),
      .iwb_dat_o(iwb_dat), .iwb_ack_o(iwb_ack),
      .dwb_adr_i(dwb_adr), .dwb_dat_i(dwb_wdat), .dwb_we_i(dwb_we), .dwb_sel_i(dwb_sel),
      .dwb_stb_i(dwb_stb), .dwb_cyc_i(dwb_cyc), .dwb_dat_o(dwb_rdat),
      .dwb_ack_o(dwb_ack), .dwb_err_o(dwb_err),
      .ext_adr_o(ext_adr), .ext_dat_o(ext_wdat), .ext_dat_i(ext_rdat), .ext_we_o(ext_we),
      .ext_sel_o(ext_sel), .ext_stb_o(ext_stb), .ext_cyc_o(ext_cyc), .ext_ack_i(ext_ack)
   );

   sp_bus_checker u_chk (.clk_i(clk));

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("Timeout after %0d cycles, an access never completed.", cycles);
         u_chk.print_summary();
         $display("Test failures found");
         $finish;
      end
   end

   // The slave acts on the strobe and address seen at the last rising edge.
   always @(posedge clk) begin
      ext_stb_q <= ext_stb;
      ext_adr_q <= ext_adr;
   end

   // External byte slave, returns the low address byte XOR 5A after 0 to 3 cycles.
   always @(negedge clk) begin
      if (!rst_n || ext_ack) begin
         ext_ack    = 1'b0;
         slave_busy = 0;
      end else if (ext_stb_q) begin
         if (!slave_busy) begin
            slave_busy  = 1;
            slave_delay = $urandom_range(3, 0);
         end
         if (slave_delay == 0) begin
            ext_ack  = 1'b1;
            ext_rdat = ext_adr_q[7:0] ^ 8'h5a;
         end else begin
            slave_delay--;
         end
      end
   end

   task automatic run_op(input logic [107:0] op);
      logic [3:0] port;
      bit         need_i;
      bit         need_d;
      bit         got_i;
      bit         got_d;
      port   = op[107:104];
      need_i = (port != 4'd0);
      need_d = (port != 4'd1);
      @(negedge clk);
      if (need_i) begin
         iwb_adr = op[99:68];
         iwb_stb = 1'b1;
         iwb_cyc = 1'b1;
      end
      if (need_d) begin
         dwb_adr  = (port == 4'd2) ? op[99:68] + 32'd4 : op[99:68];
         dwb_we   = op[100];
         dwb_sel  = op[67:64];
         dwb_wdat = op[63:32];
         dwb_stb  = 1'b1;
         dwb_cyc  = 1'b1;
      end
      while (need_i || need_d) begin
         @(posedge clk);
         got_i = need_i && iwb_ack;
         got_d = need_d && (dwb_ack || dwb_err);
         @(negedge clk);
         if (got_i) begin
            iwb_stb = 1'b0;
            iwb_cyc = 1'b0;
            need_i  = 0;
         end
         if (got_d) begin
            dwb_stb = 1'b0;
            dwb_cyc = 1'b0;
            dwb_we  = 1'b0;
            need_d  = 0;
         end
      end
   endtask

   initial begin
      void'($urandom(32'h8d34aeac));
      rst_n    = 1'b0;
      iwb_adr  = '0;
      iwb_stb  = 1'b0;
      iwb_cyc  = 1'b0;
      dwb_adr  = '0;
      dwb_wdat = '0;
      dwb_we   = 1'b0;
      dwb_sel  = '0;
      dwb_stb  = 1'b0;
      dwb_cyc  = 1'b0;
      ext_rdat = '0;
      ext_ack  = 1'b0;
      $readmemh("tests/sp_bus_golden.hex", golden);
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int i = 0; i < N_OPS; i++) begin
         run_op(golden[i]);
      end
      repeat (2) @(negedge clk);
      u_chk.print_summary();
      if (u_chk.total_errors() == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire
